/* Makefile */
TOP := cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* common/lc3b_pkg.sv */
package lc3b_pkg;

    // Basic widths
    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // LC-3b opcode field, IR[15:12]
    // Only the supported subset is named; anything else decodes as a NOP
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_jmp = 4'b1100,
        op_lea = 4'b1110
    } lc3b_opcode;

    // ALU operation
    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } alu_op_e;

    // ALU B operand source
    typedef enum logic [1:0] {
        sel_reg,
        sel_imm5,
        sel_off6
    } alumux_sel_e;

    // Register file write-back source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mdr,
        wb_pcoff
    } wbmux_sel_e;

    // Shared memory port phase within one pipeline step
    typedef enum logic {
        phase_data  = 1'b0,
        phase_fetch = 1'b1
    } mem_phase_e;

endpackage : lc3b_pkg

/* cpu/cpu_control.sv */
module cpu_control
    import lc3b_pkg::*;
(
    input  lc3b_opcode  opcode,
    input  logic        ir_5,
    output alu_op_e     alu_op,
    output alumux_sel_e alumux_sel,
    output wbmux_sel_e  wbmux_sel,
    output logic        load_regfile,
    output logic        load_cc,
    output logic        mem_rd,
    output logic        mem_wr,
    output logic        is_branch,
    output logic        is_jmp
);

    always_comb begin
        // Inactive levels, also used for unsupported opcodes
        alu_op       = alu_add;
        alumux_sel   = sel_reg;
        wbmux_sel    = wb_alu;
        load_regfile = 1'b0;
        load_cc      = 1'b0;
        mem_rd       = 1'b0;
        mem_wr       = 1'b0;
        is_branch    = 1'b0;
        is_jmp       = 1'b0;

        case (opcode)
            op_add, op_and: begin
                alu_op       = (opcode == op_add) ? alu_add : alu_and;
                // IR[5] picks imm5 over SR2
                alumux_sel   = ir_5 ? sel_imm5 : sel_reg;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_not: begin
                alu_op       = alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_ldr: begin
                alumux_sel   = sel_off6;
                wbmux_sel    = wb_mdr;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                mem_rd       = 1'b1;
            end
            op_str: begin
                alumux_sel = sel_off6;
                mem_wr     = 1'b1;
            end
            op_lea: begin
                wbmux_sel    = wb_pcoff;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_br: begin
                is_branch = 1'b1;
            end
            op_jmp: begin
                // Base register comes through on the B operand
                alu_op = alu_pass;
                is_jmp = 1'b1;
            end
            default: ;
        endcase
    end

endmodule : cpu_control

/* cpu/cpu_datapath.sv */
module cpu_datapath
    import lc3b_pkg::*;
#(
    parameter lc3b_word reset_vector = 16'h0000
)
(
    input  logic        clk,
    input  logic        arst_n,
    input  alu_op_e     alu_op,
    input  alumux_sel_e alumux_sel,
    input  wbmux_sel_e  wbmux_sel,
    input  logic        load_regfile,
    input  logic        load_cc,
    input  logic        mem_rd,
    input  logic        mem_wr,
    input  logic        is_branch,
    input  logic        is_jmp,
    output lc3b_opcode  opcode,
    output logic        ir_5,
    input  logic        mem_resp,
    input  lc3b_word    mem_rdata,
    output logic        mem_read,
    output logic        mem_write,
    output lc3b_word    mem_address,
    output lc3b_word    mem_wdata
);

    mem_phase_e phase;
    logic       idle, advance, branch_taken;
    lc3b_word   pc, pc_plus2, pc_next, mdr;

    logic     ifid_valid;
    lc3b_word ifid_pc, ifid_ir;
    lc3b_reg  src_b;
    lc3b_word reg_a, reg_b;

    logic        idex_valid, idex_load_regfile, idex_load_cc, idex_mem_rd, idex_mem_wr;
    logic        idex_is_branch, idex_is_jmp;
    lc3b_word    idex_pc, idex_ir, idex_a, idex_b;
    alu_op_e     idex_alu_op;
    alumux_sel_e idex_alumux_sel;
    wbmux_sel_e  idex_wbmux_sel;
    lc3b_word    alumux_out, alu_out;

    logic       exmem_valid, exmem_load_regfile, exmem_load_cc, exmem_mem_rd, exmem_mem_wr;
    logic       exmem_is_branch, exmem_is_jmp;
    lc3b_word   exmem_pc, exmem_ir, exmem_alu, exmem_wdata;
    wbmux_sel_e exmem_wbmux_sel;

    logic       memwb_valid, memwb_load_regfile, memwb_load_cc, memwb_is_branch, memwb_is_jmp;
    lc3b_word   memwb_pc, memwb_ir, memwb_alu, memwb_mdr;
    wbmux_sel_e memwb_wbmux_sel;
    lc3b_word   pc_offset, wb_value, wb_data;
    lc3b_nzp    wb_nzp, cc;

    // Port sequencer: optional data phase, then the fetch that advances everything
    assign advance     = mem_resp & (phase == phase_fetch);
    assign mem_read    = ~idle & ((phase == phase_fetch) | exmem_mem_rd);
    assign mem_write   = ~idle & (phase == phase_data) & exmem_mem_wr;
    assign mem_address = (phase == phase_data) ? exmem_alu : pc;
    assign mem_wdata   = exmem_wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= phase_fetch;
            idle  <= 1'b1;
        end else begin
            // One quiet cycle after every response
            idle <= mem_resp;
            if (advance)
                phase <= (idex_valid & (idex_mem_rd | idex_mem_wr)) ? phase_data : phase_fetch;
            else if (mem_resp)
                phase <= phase_fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_resp & (phase == phase_data) & exmem_mem_rd)
            mdr <= mem_rdata;
    end

    // PC and branch resolution in WB
    assign pc_plus2     = pc + 16'd2;
    assign pc_offset    = memwb_pc + {{6{memwb_ir[8]}}, memwb_ir[8:0], 1'b0};
    assign branch_taken = memwb_valid & (memwb_is_jmp | (memwb_is_branch & |(memwb_ir[11:9] & cc)));
    assign pc_next      = !branch_taken ? pc_plus2 : (memwb_is_jmp ? memwb_alu : pc_offset);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= reset_vector;
            cc          <= 3'b010;
            ifid_valid  <= 1'b0;
            idex_valid  <= 1'b0;
            exmem_valid <= 1'b0;
            memwb_valid <= 1'b0;
        end else if (advance) begin
            pc          <= pc_next;
            ifid_valid  <= 1'b1;
            idex_valid  <= ifid_valid;
            exmem_valid <= idex_valid;
            memwb_valid <= exmem_valid;
            if (memwb_valid & memwb_load_cc)
                cc <= wb_nzp;
        end
    end

    // ID stage
    assign opcode = lc3b_opcode'(ifid_ir[15:12]);
    assign ir_5   = ifid_ir[5];
    // STR reads its source at IR[11:9], JMP its base at IR[8:6]
    assign src_b  = (opcode == op_str) ? ifid_ir[11:9] :
                    (opcode == op_jmp) ? ifid_ir[8:6] : ifid_ir[2:0];

    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (advance & memwb_valid & memwb_load_regfile),
        .dest   (memwb_ir[11:9]),
        .in     (wb_data),
        .src_a  (ifid_ir[8:6]),
        .src_b  (src_b),
        .reg_a  (reg_a),
        .reg_b  (reg_b)
    );

    // EX stage
    always_comb begin
        case (idex_alumux_sel)
            sel_imm5: alumux_out = {{11{idex_ir[4]}}, idex_ir[4:0]};
            sel_off6: alumux_out = {{9{idex_ir[5]}}, idex_ir[5:0], 1'b0};
            default:  alumux_out = idex_b;
        endcase
    end

    alu u_alu (
        .aluop (idex_alu_op),
        .a     (idex_a),
        .b     (alumux_out),
        .f     (alu_out),
        .nzp   ()
    );

    // WB stage value, passed through a second ALU for the condition codes
    always_comb begin
        case (memwb_wbmux_sel)
            wb_mdr:   wb_value = memwb_mdr;
            wb_pcoff: wb_value = pc_offset;
            default:  wb_value = memwb_alu;
        endcase
    end

    alu u_cc_alu (
        .aluop (alu_pass),
        .a     (16'h0000),
        .b     (wb_value),
        .f     (wb_data),
        .nzp   (wb_nzp)
    );

    // Pipeline payload, gated by the valid bits above
    always_ff @(posedge clk) begin
        if (advance) begin
            ifid_pc            <= pc_plus2;
            ifid_ir            <= mem_rdata;

            idex_pc            <= ifid_pc;
            idex_ir            <= ifid_ir;
            idex_a             <= reg_a;
            idex_b             <= reg_b;
            idex_alu_op        <= alu_op;
            idex_alumux_sel    <= alumux_sel;
            idex_wbmux_sel     <= wbmux_sel;
            idex_load_regfile  <= load_regfile;
            idex_load_cc       <= load_cc;
            idex_mem_rd        <= mem_rd;
            idex_mem_wr        <= mem_wr;
            idex_is_branch     <= is_branch;
            idex_is_jmp        <= is_jmp;

            exmem_pc           <= idex_pc;
            exmem_ir           <= idex_ir;
            exmem_alu          <= alu_out;
            exmem_wdata        <= idex_b;
            exmem_wbmux_sel    <= idex_wbmux_sel;
            exmem_load_regfile <= idex_load_regfile;
            exmem_load_cc      <= idex_load_cc;
            exmem_mem_rd       <= idex_mem_rd;
            exmem_mem_wr       <= idex_mem_wr;
            exmem_is_branch    <= idex_is_branch;
            exmem_is_jmp       <= idex_is_jmp;

            memwb_pc           <= exmem_pc;
            memwb_ir           <= exmem_ir;
            memwb_alu          <= exmem_alu;
            memwb_mdr          <= mdr;
            memwb_wbmux_sel    <= exmem_wbmux_sel;
            memwb_load_regfile <= exmem_load_regfile;
            memwb_load_cc      <= exmem_load_cc;
            memwb_is_branch    <= exmem_is_branch;
            memwb_is_jmp       <= exmem_is_jmp;
        end
    end

endmodule : cpu_datapath

/* dv/cpu_props.sv */
module cpu_props
    import lc3b_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       mem_read,
    input logic       mem_write,
    input logic       mem_resp,
    input lc3b_word   mem_address,
    input mem_phase_e phase
);

    // Read and write are exclusive
    exclusive_request: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mem_read && mem_write)
    ) else $error("mem_read and mem_write are high together");

    // A request holds until its response
    stable_request: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_read || mem_write) && !mem_resp |=>
            $stable(mem_address) && $stable(mem_read) && $stable(mem_write) && $stable(phase)
    ) else $error("memory request changed before mem_resp");

    // No write in reset or in the cycle after it
    quiet_reset: assert property (
        @(posedge clk)
        (!arst_n || !$past(arst_n)) |-> !mem_write
    ) else $error("mem_write high during or right after reset");

endmodule : cpu_props

bind cpu_datapath cpu_props u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_resp    (mem_resp),
    .mem_address (mem_address),
    .phase       (phase)
);

/* dv/cpu_stim.txt */
# tag  byte_address  word
# tag P is a program or data word, tag E the next expected store (address, data)
# ALU results, R7 = 0x0100 is the store base
P 0000 EE7F
P 0002 1225
P 0004 143D
P 000A 1642
P 000C 586C
P 000E 9ABF
P 0010 5C42
P 0016 77C0
P 0018 79C1
P 001A 7BC2
P 001C 7DC3
P 001E 75C4
# LDR from 0x013E and LEA
P 0020 63DF
P 0022 E408
P 0028 73C5
P 002A 75C6
# BR on n, z and p, each not taken then taken
P 002C 183F
P 002E 0605
P 0038 0805
P 0042 79C7
P 0044 79C8
P 0046 5A20
P 0048 0A05
P 0052 0405
P 005C 7BC9
P 005E 7BCA
P 0060 1227
P 0062 0C05
P 006C 0205
P 0076 73CB
P 0078 73CC
# JMP through R2 to 0x0090
P 007A E40A
P 0080 C080
P 008A 75CD
P 0090 75CE
# Data word for the LDR
P 013E BEEF
# Stores in program order
E 0100 0002
E 0102 0004
E 0104 0002
E 0106 0005
E 0108 FFFD
E 010A BEEF
E 010C 0034
E 0110 FFFF
E 0114 0000
E 0118 0007
E 011C 0090

/* dv/cpu_tb.sv */
module cpu_tb
    import lc3b_pkg::*;
();

    localparam int       max_wait     = 200;
    localparam int       max_requests = 400;
    localparam int       drain_count  = 40;
    // Junk between responses, a stray sample would decode as an ADD to R7
    localparam lc3b_word idle_rdata   = 16'h1FFF;

    logic     clk;
    logic     arst_n;
    logic     mem_resp;
    lc3b_word mem_rdata;
    logic     mem_read;
    logic     mem_write;
    lc3b_word mem_address;
    lc3b_word mem_wdata;

    lc3b_word    mem [256];
    lc3b_word    exp_addr [$];
    lc3b_word    exp_data [$];
    int          store_count;
    logic [31:0] rng_state;

    cpu UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_resp    (mem_resp),
        .mem_rdata   (mem_rdata),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run;
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input lc3b_word got, input lc3b_word exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic load_stim;
        int                fd;
        int                n;
        logic [7:0]        tag;
        logic [8*128-1:0]  rest;
        lc3b_word          a;
        lc3b_word          d;
        for (int i = 0; i < 256; i++)
            mem[i] = 16'h0000;
        fd = $fopen("dv/cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/cpu_stim.txt");
            stop_run();
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "P" || tag == "E") begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) begin
                    $display("Malformed line in the stimulus file");
                    stop_run();
                end
                if (tag == "P") begin
                    mem[a[8:1]] = d;
                end else begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
            end else begin
                $display("Unknown line tag in the stimulus file");
                stop_run();
            end
        end
        $fclose(fd);
    endtask

    // One memory transaction, entered and left on a falling edge
    task automatic serve_request(input bit stores_allowed);
        int       waited;
        int       latency;
        logic     is_write;
        lc3b_word addr;
        waited = 0;
        while (!(mem_read || mem_write)) begin
            if (waited == max_wait) begin
                $display("Timeout: the CPU made no memory request in %0d cycles", max_wait);
                stop_run();
            end
            waited++;
            @(negedge clk);
        end
        check_level("mem_read with mem_write", mem_read & mem_write, 1'b0);
        is_write  = mem_write;
        addr      = mem_address;
        rng_state = xorshift(rng_state);
        latency   = int'(rng_state[1:0]);
        repeat (latency) begin
            @(negedge clk);
            check_level("held mem_write", mem_write, is_write);
            check_level("held mem_read", mem_read, !is_write);
            check_word("held mem_address", mem_address, addr);
        end
        mem_resp = 1'b1;
        if (is_write) begin
            if (!stores_allowed) begin
                $display("Unexpected store to %h after the last expected store", addr);
                stop_run();
            end
            check_word("store address", addr, exp_addr[store_count]);
            check_word("store data", mem_wdata, exp_data[store_count]);
            store_count++;
            mem[addr[8:1]] = mem_wdata;
        end else begin
            mem_rdata = mem[addr[8:1]];
        end
        @(negedge clk);
        mem_resp  = 1'b0;
        mem_rdata = idle_rdata;
        check_level("request level after mem_resp", mem_read | mem_write, 1'b0);
    endtask

    initial begin
        int served;
        arst_n      = 1'b0;
        mem_resp    = 1'b0;
        mem_rdata   = idle_rdata;
        rng_state   = 32'had7b_e9d3;
        store_count = 0;
        served      = 0;
        load_stim();
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        while (store_count < exp_addr.size()) begin
            if (served == max_requests) begin
                $display("Timeout: %0d of %0d stores seen after %0d memory requests",
                         store_count, exp_addr.size(), max_requests);
                stop_run();
            end
            serve_request(1'b1);
            served++;
        end

        // Keep fetching NOPs past the program, no further store may show up
        repeat (drain_count) serve_request(1'b0);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : cpu_tb

/* hdl/alu.sv */
module alu
    import lc3b_pkg::*;
(
    input  alu_op_e  aluop,
    input  lc3b_word a,
    input  lc3b_word b,
    output lc3b_word f,
    output lc3b_nzp  nzp
);

    always_comb begin
        case (aluop)
            alu_add: f = a + b;
            alu_and: f = a & b;
            alu_not: f = ~a;
            default: f = b;
        endcase
    end

    // Condition codes of the result
    assign nzp[2] = f[15];
    assign nzp[1] = (f == 16'h0000);
    assign nzp[0] = ~f[15] & (f != 16'h0000);

endmodule : alu

/* hdl/cpu.sv */
module cpu
    import lc3b_pkg::*;
#(
    parameter lc3b_word reset_vector = 16'h0000
)
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     mem_resp,
    input  lc3b_word mem_rdata,
    output logic     mem_read,
    output logic     mem_write,
    output lc3b_word mem_address,
    output lc3b_word mem_wdata
);

    lc3b_opcode  opcode;
    logic        ir_5;
    alu_op_e     alu_op;
    alumux_sel_e alumux_sel;
    wbmux_sel_e  wbmux_sel;
    logic        load_regfile, load_cc, mem_rd, mem_wr, is_branch, is_jmp;

    cpu_control u_control (
        .opcode       (opcode),
        .ir_5         (ir_5),
        .alu_op       (alu_op),
        .alumux_sel   (alumux_sel),
        .wbmux_sel    (wbmux_sel),
        .load_regfile (load_regfile),
        .load_cc      (load_cc),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .is_branch    (is_branch),
        .is_jmp       (is_jmp)
    );

    cpu_datapath #(
        .reset_vector (reset_vector)
    ) u_datapath (
        .clk          (clk),
        .arst_n       (arst_n),
        .alu_op       (alu_op),
        .alumux_sel   (alumux_sel),
        .wbmux_sel    (wbmux_sel),
        .load_regfile (load_regfile),
        .load_cc      (load_cc),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .is_branch    (is_branch),
        .is_jmp       (is_jmp),
        .opcode       (opcode),
        .ir_5         (ir_5),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata)
    );

endmodule : cpu

/* hdl/regfile.sv */
module regfile
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  lc3b_reg  dest,
    input  lc3b_word in,
    input  lc3b_reg  src_a,
    input  lc3b_reg  src_b,
    output lc3b_word reg_a,
    output lc3b_word reg_b
);

    lc3b_word regs [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // Write-through so ID sees the WB result in the same cycle
    assign reg_a = (load && dest == src_a) ? in : regs[src_a];
    assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule : regfile

/* list.f */
common/lc3b_pkg.sv
hdl/regfile.sv
hdl/alu.sv
cpu/cpu_control.sv
cpu/cpu_datapath.sv
hdl/cpu.sv
dv/cpu_props.sv
dv/cpu_tb.sv
